//--- alu.sv
`timescale 1ns/1ps

module alu (
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  mips_pkg::alu_op_t op,
   output mips_pkg::word_t   y
);

   always_comb begin
      case (op)
         mips_pkg::ALU_SUB: y = a - b;
         mips_pkg::ALU_OR:  y = a | b;
         // immediate to upper half
         mips_pkg::ALU_LUI: y = {b[15:0], 16'h0000};
         default:           y = a + b;
      endcase
   end

endmodule

//--- cpu.f
mips_pkg.sv
ifu.sv
ctrl.sv
grf.sv
alu.sv
stall_unit.sv
cpu.sv
cpu_assertions.sv
tb_cpu.sv

//--- cpu.sv
`timescale 1ns/1ps

module cpu #(
   parameter mips_pkg::word_t RESET_PC = 32'h0000_3000
) (
   input  logic                clk,
   input  logic                rst,
   output mips_pkg::word_t     i_inst_addr,
   input  mips_pkg::word_t     i_inst_rdata,
   output mips_pkg::word_t     m_data_addr,
   output mips_pkg::word_t     m_data_wdata,
   output logic [3:0]          m_data_byteen,
   output mips_pkg::word_t     m_inst_addr,
   input  mips_pkg::word_t     m_data_rdata,
   output logic                w_grf_we,
   output mips_pkg::reg_addr_t w_grf_addr,
   output mips_pkg::word_t     w_grf_wdata,
   output mips_pkg::word_t     w_inst_addr
);

   // zero first, then the nearest stage ahead
   function automatic mips_pkg::word_t pick(
      input mips_pkg::reg_addr_t src,
      input mips_pkg::reg_addr_t e_dst,
      input mips_pkg::word_t     e_val,
      input mips_pkg::reg_addr_t m_dst,
      input mips_pkg::word_t     m_val,
      input mips_pkg::reg_addr_t w_dst,
      input mips_pkg::word_t     w_val,
      input mips_pkg::word_t     rf_val
   );
      if (src == 5'd0) begin
         return '0;
      end else if (src == e_dst) begin
         return e_val;
      end else if (src == m_dst) begin
         return m_val;
      end else if (src == w_dst) begin
         return w_val;
      end
      return rf_val;
   endfunction

   logic pc_en;
   logic fd_en;
   logic de_flush;

   mips_pkg::word_t     d_instr, d_pc;
   mips_pkg::reg_addr_t d_rs, d_rt;
   mips_pkg::npc_op_t   d_npc_op;
   logic                d_zero_ext, d_reads_rs, d_reads_rt;
   mips_pkg::word_t     d_rd1, d_rd2, d_rs_fwd, d_rt_fwd, d_ext;
   logic                branch_taken;

   mips_pkg::word_t     e_instr, e_pc, e_rs_val, e_rt_val, e_imm;
   mips_pkg::reg_addr_t e_rs, e_rt, e_dest;
   mips_pkg::alu_op_t   e_alu_op;
   mips_pkg::wd_sel_t   e_wd_sel;
   logic                e_use_imm, e_early_ready;
   mips_pkg::word_t     e_rs_fwd, e_rt_fwd, e_alu_y, e_fwd_val;

   mips_pkg::word_t     m_instr, m_pc, m_alu_y, m_rt_val;
   mips_pkg::reg_addr_t m_dest;
   mips_pkg::wd_sel_t   m_wd_sel;
   logic                m_mem_write;

   mips_pkg::word_t     w_instr, w_pc, w_alu_y, w_dm, w_wd;
   mips_pkg::reg_addr_t w_dest;
   mips_pkg::wd_sel_t   w_wd_sel;

   ifu #(.RESET_PC(RESET_PC)) u_ifu (
      .clk(clk), .rst(rst), .en(pc_en),
      .npc_op(d_npc_op), .branch_taken(branch_taken),
      .imm(d_ext), .jump_index(d_instr[25:0]), .d_pc(d_pc),
      .i_inst_addr(i_inst_addr)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         d_instr <= '0;
      end else if (fd_en) begin
         d_instr <= i_inst_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (fd_en) begin
         d_pc <= i_inst_addr;
      end
   end

   ctrl d_ctrl (
      .instr(d_instr), .rs(d_rs), .rt(d_rt), .dest(), .alu_op(), .use_imm(),
      .zero_ext(d_zero_ext), .wd_sel(), .mem_write(), .npc_op(d_npc_op),
      .reads_rs_in_d(d_reads_rs), .reads_rt_in_d(d_reads_rt), .early_ready()
   );

   grf u_grf (
      .clk(clk), .rst(rst), .ra1(d_rs), .ra2(d_rt),
      .wa(w_dest), .wd(w_wd), .we(w_wd_sel != mips_pkg::WD_NONE), .wpc(w_pc),
      .rd1(d_rd1), .rd2(d_rd2),
      .w_grf_we(w_grf_we), .w_grf_addr(w_grf_addr),
      .w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr)
   );

   assign d_ext = d_zero_ext ? {16'h0000, d_instr[15:0]} :
                  {{16{d_instr[15]}}, d_instr[15:0]};

   // execute only supplies lui, memory only alu results
   assign d_rs_fwd = pick(d_rs, e_dest, e_fwd_val, m_dest, m_alu_y, w_dest, w_wd, d_rd1);
   assign d_rt_fwd = pick(d_rt, e_dest, e_fwd_val, m_dest, m_alu_y, w_dest, w_wd, d_rd2);
   assign branch_taken = (d_rs_fwd == d_rt_fwd);

   stall_unit u_stall_unit (
      .d_rs(d_rs), .d_rt(d_rt),
      .reads_rs_in_d(d_reads_rs), .reads_rt_in_d(d_reads_rt),
      .e_dest(e_dest), .m_dest(m_dest),
      .e_is_load(e_wd_sel == mips_pkg::WD_DM), .e_early_ready(e_early_ready),
      .m_is_load(m_wd_sel == mips_pkg::WD_DM),
      .pc_en(pc_en), .fd_en(fd_en), .de_flush(de_flush)
   );

   // bubble on stall
   always_ff @(posedge clk) begin
      if (rst || de_flush) begin
         e_instr <= '0;
      end else begin
         e_instr <= d_instr;
      end
   end

   always_ff @(posedge clk) begin
      e_pc     <= d_pc;
      e_rs_val <= d_rs_fwd;
      e_rt_val <= d_rt_fwd;
      e_imm    <= d_ext;
   end

   ctrl e_ctrl (
      .instr(e_instr), .rs(e_rs), .rt(e_rt), .dest(e_dest), .alu_op(e_alu_op),
      .use_imm(e_use_imm), .zero_ext(), .wd_sel(e_wd_sel), .mem_write(),
      .npc_op(), .reads_rs_in_d(), .reads_rt_in_d(), .early_ready(e_early_ready)
   );

   assign e_fwd_val = {e_imm[15:0], 16'h0000};
   assign e_rs_fwd  = pick(e_rs, 5'd0, '0, m_dest, m_alu_y, w_dest, w_wd, e_rs_val);
   assign e_rt_fwd  = pick(e_rt, 5'd0, '0, m_dest, m_alu_y, w_dest, w_wd, e_rt_val);

   alu u_alu (
      .a(e_rs_fwd), .b(e_use_imm ? e_imm : e_rt_fwd), .op(e_alu_op), .y(e_alu_y)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         m_instr <= '0;
         w_instr <= '0;
      end else begin
         m_instr <= e_instr;
         w_instr <= m_instr;
      end
   end

   always_ff @(posedge clk) begin
      m_pc     <= e_pc;
      m_alu_y  <= e_alu_y;
      m_rt_val <= e_rt_fwd;
      w_pc     <= m_pc;
      w_alu_y  <= m_alu_y;
      w_dm     <= m_data_rdata;
   end

   ctrl m_ctrl (
      .instr(m_instr), .rs(), .rt(), .dest(m_dest), .alu_op(), .use_imm(),
      .zero_ext(), .wd_sel(m_wd_sel), .mem_write(m_mem_write), .npc_op(),
      .reads_rs_in_d(), .reads_rt_in_d(), .early_ready()
   );

   assign m_data_addr   = m_alu_y;
   assign m_data_wdata  = m_rt_val;
   assign m_data_byteen = m_mem_write ? 4'hf : 4'h0;
   assign m_inst_addr   = m_pc;

   ctrl w_ctrl (
      .instr(w_instr), .rs(), .rt(), .dest(w_dest), .alu_op(), .use_imm(),
      .zero_ext(), .wd_sel(w_wd_sel), .mem_write(), .npc_op(),
      .reads_rs_in_d(), .reads_rt_in_d(), .early_ready()
   );

   assign w_wd = (w_wd_sel == mips_pkg::WD_DM) ? w_dm : w_alu_y;

endmodule

//--- cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
   input logic                clk,
   input logic                rst,
   input logic [3:0]          m_data_byteen,
   input mips_pkg::word_t     m_data_addr,
   input logic                w_grf_we,
   input mips_pkg::reg_addr_t w_grf_addr
);

   // quiet ports in the cycle after a reset edge
   reset_quiet: assert property (
      @(posedge clk) $past(rst) |-> (!w_grf_we && m_data_byteen == 4'h0)
   ) else $error("register write or store right after reset");

   byteen_word: assert property (
      @(posedge clk) disable iff (rst)
      (m_data_byteen == 4'h0 || m_data_byteen == 4'hf)
   ) else $error("partial byte enable on the data port");

   store_aligned: assert property (
      @(posedge clk) disable iff (rst)
      (m_data_byteen != 4'h0) |-> (m_data_addr[1:0] == 2'b00)
   ) else $error("store address not word aligned");

   // r0 writes are hidden from the trace
   trace_nonzero: assert property (
      @(posedge clk) disable iff (rst)
      w_grf_we |-> (w_grf_addr != 5'd0)
   ) else $error("trace reports a write to register zero");

endmodule

bind cpu cpu_assertions u_cpu_assertions (
   .clk(clk),
   .rst(rst),
   .m_data_byteen(m_data_byteen),
   .m_data_addr(m_data_addr),
   .w_grf_we(w_grf_we),
   .w_grf_addr(w_grf_addr)
);

//--- ctrl.sv
`timescale 1ns/1ps

module ctrl (
   input  mips_pkg::word_t     instr,
   output mips_pkg::reg_addr_t rs,
   output mips_pkg::reg_addr_t rt,
   output mips_pkg::reg_addr_t dest,
   output mips_pkg::alu_op_t   alu_op,
   output logic                use_imm,
   output logic                zero_ext,
   output mips_pkg::wd_sel_t   wd_sel,
   output logic                mem_write,
   output mips_pkg::npc_op_t   npc_op,
   output logic                reads_rs_in_d,
   output logic                reads_rt_in_d,
   output logic                early_ready
);

   logic [5:0] opcode;
   logic [5:0] funct;
   logic is_addu;
   logic is_subu;
   logic is_ori;
   logic is_lui;
   logic is_lw;
   logic is_sw;
   logic is_beq;
   logic is_j;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];

   assign is_addu = (opcode == mips_pkg::OP_SPECIAL) && (funct == mips_pkg::FN_ADDU);
   assign is_subu = (opcode == mips_pkg::OP_SPECIAL) && (funct == mips_pkg::FN_SUBU);
   assign is_ori  = (opcode == mips_pkg::OP_ORI);
   assign is_lui  = (opcode == mips_pkg::OP_LUI);
   assign is_lw   = (opcode == mips_pkg::OP_LW);
   assign is_sw   = (opcode == mips_pkg::OP_SW);
   assign is_beq  = (opcode == mips_pkg::OP_BEQ);
   assign is_j    = (opcode == mips_pkg::OP_J);

   // unused source fields read as r0 so they never match a hazard
   assign rs = (is_addu || is_subu || is_ori || is_lw || is_sw || is_beq) ?
               instr[25:21] : 5'd0;
   assign rt = (is_addu || is_subu || is_sw || is_beq) ? instr[20:16] : 5'd0;

   always_comb begin
      if (is_addu || is_subu) begin
         dest = instr[15:11];
      end else if (is_ori || is_lui || is_lw) begin
         dest = instr[20:16];
      end else begin
         dest = 5'd0;
      end
   end

   always_comb begin
      if (is_subu) begin
         alu_op = mips_pkg::ALU_SUB;
      end else if (is_ori) begin
         alu_op = mips_pkg::ALU_OR;
      end else if (is_lui) begin
         alu_op = mips_pkg::ALU_LUI;
      end else begin
         alu_op = mips_pkg::ALU_ADD;
      end
   end

   assign use_imm  = is_ori || is_lui || is_lw || is_sw;
   assign zero_ext = is_ori;

   assign wd_sel = is_lw ? mips_pkg::WD_DM :
                   (is_addu || is_subu || is_ori || is_lui) ? mips_pkg::WD_ALU :
                   mips_pkg::WD_NONE;

   assign mem_write = is_sw;

   assign npc_op = is_beq ? mips_pkg::NPC_BEQ :
                   is_j   ? mips_pkg::NPC_J   : mips_pkg::NPC_SEQ;

   // beq compares in decode
   assign reads_rs_in_d = is_beq;
   assign reads_rt_in_d = is_beq;
   assign early_ready   = is_lui;

endmodule

//--- grf.sv
`timescale 1ns/1ps

module grf (
   input  logic                clk,
   input  logic                rst,
   input  mips_pkg::reg_addr_t ra1,
   input  mips_pkg::reg_addr_t ra2,
   input  mips_pkg::reg_addr_t wa,
   input  mips_pkg::word_t     wd,
   input  logic                we,
   input  mips_pkg::word_t     wpc,
   output mips_pkg::word_t     rd1,
   output mips_pkg::word_t     rd2,
   output logic                w_grf_we,
   output mips_pkg::reg_addr_t w_grf_addr,
   output mips_pkg::word_t     w_grf_wdata,
   output mips_pkg::word_t     w_inst_addr
);

   mips_pkg::word_t regs [0:31];
   logic wr_live;

   // r0 is never written
   assign wr_live = we && (wa != 5'd0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wa] <= wd;
      end
   end

   // write-through
   assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
   assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

   assign w_grf_we    = wr_live;
   assign w_grf_addr  = wa;
   assign w_grf_wdata = wd;
   assign w_inst_addr = wpc;

endmodule

//--- ifu.sv
`timescale 1ns/1ps

module ifu #(
   parameter mips_pkg::word_t RESET_PC = 32'h0000_3000
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              en,
   input  mips_pkg::npc_op_t npc_op,
   input  logic              branch_taken,
   input  mips_pkg::word_t   imm,
   input  logic [25:0]       jump_index,
   input  mips_pkg::word_t   d_pc,
   output mips_pkg::word_t   i_inst_addr
);

   mips_pkg::word_t pc;
   mips_pkg::word_t npc;
   mips_pkg::word_t d_pc_plus4;

   // targets are relative to the delay slot
   assign d_pc_plus4 = d_pc + 32'd4;

   always_comb begin
      npc = pc + 32'd4;
      case (npc_op)
         mips_pkg::NPC_BEQ: begin
            if (branch_taken) begin
               npc = d_pc_plus4 + {imm[29:0], 2'b00};
            end
         end
         mips_pkg::NPC_J: begin
            npc = {d_pc_plus4[31:28], jump_index, 2'b00};
         end
         default: begin
            npc = pc + 32'd4;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= RESET_PC;
      end else if (en) begin
         pc <= npc;
      end
   end

   assign i_inst_addr = pc;

endmodule

//--- mips_pkg.sv
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   // alu operations
   typedef logic [1:0] alu_op_t;
   localparam alu_op_t ALU_ADD = 2'd0;
   localparam alu_op_t ALU_SUB = 2'd1;
   localparam alu_op_t ALU_OR  = 2'd2;
   localparam alu_op_t ALU_LUI = 2'd3;

   // register write source
   typedef logic [1:0] wd_sel_t;
   localparam wd_sel_t WD_ALU  = 2'd0;
   localparam wd_sel_t WD_DM   = 2'd1;
   localparam wd_sel_t WD_NONE = 2'd2;

   // next pc kind, resolved in decode
   typedef logic [1:0] npc_op_t;
   localparam npc_op_t NPC_SEQ = 2'd0;
   localparam npc_op_t NPC_BEQ = 2'd1;
   localparam npc_op_t NPC_J   = 2'd2;

   // primary opcodes
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_SW      = 6'h2b;
   localparam logic [5:0] OP_BEQ     = 6'h04;
   localparam logic [5:0] OP_J       = 6'h02;

   // funct field of special
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f cpu.f -o tb_cpu_sim

status=0
./obj_dir/tb_cpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

//--- stall_unit.sv
`timescale 1ns/1ps

module stall_unit (
   input  mips_pkg::reg_addr_t d_rs,
   input  mips_pkg::reg_addr_t d_rt,
   input  logic                reads_rs_in_d,
   input  logic                reads_rt_in_d,
   input  mips_pkg::reg_addr_t e_dest,
   input  mips_pkg::reg_addr_t m_dest,
   input  logic                e_is_load,
   input  logic                e_early_ready,
   input  logic                m_is_load,
   output logic                pc_en,
   output logic                fd_en,
   output logic                de_flush
);

   logic e_hit_rs;
   logic e_hit_rt;
   logic m_hit_rs;
   logic m_hit_rt;
   logic e_hit_d;
   logic m_hit_d;
   logic stall;

   // unused sources arrive as r0
   assign e_hit_rs = (d_rs != 5'd0) && (d_rs == e_dest);
   assign e_hit_rt = (d_rt != 5'd0) && (d_rt == e_dest);
   assign m_hit_rs = (d_rs != 5'd0) && (d_rs == m_dest);
   assign m_hit_rt = (d_rt != 5'd0) && (d_rt == m_dest);

   assign e_hit_d = (reads_rs_in_d && e_hit_rs) || (reads_rt_in_d && e_hit_rt);
   assign m_hit_d = (reads_rs_in_d && m_hit_rs) || (reads_rt_in_d && m_hit_rt);

   // decode compare, then load-use in execute
   assign stall = (e_hit_d && !e_early_ready) ||
                  (m_hit_d && m_is_load) ||
                  (e_is_load && (e_hit_rs || e_hit_rt));

   assign pc_en    = !stall;
   assign fd_en    = !stall;
   assign de_flush = stall;

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

   localparam mips_pkg::word_t RESET_PC = 32'h0000_3000;

   logic                clk;
   logic                rst;
   mips_pkg::word_t     i_inst_addr;
   mips_pkg::word_t     i_inst_rdata;
   mips_pkg::word_t     m_data_addr;
   mips_pkg::word_t     m_data_wdata;
   logic [3:0]          m_data_byteen;
   mips_pkg::word_t     m_inst_addr;
   mips_pkg::word_t     m_data_rdata;
   logic                w_grf_we;
   mips_pkg::reg_addr_t w_grf_addr;
   mips_pkg::word_t     w_grf_wdata;
   mips_pkg::word_t     w_inst_addr;

   mips_pkg::word_t prog [0:255];
   mips_pkg::word_t dmem [0:63];
   mips_pkg::word_t ref_regs [0:31];
   mips_pkg::word_t ref_mem [0:63];
   int              prog_len;
   mips_pkg::word_t loop_addr;
   logic            built;
   logic [31:0]     rng_state;
   int              err_count;
   int              write_count;
   int              store_count;
   int              exp_writes;

   // expected register writes and stores, in program order
   mips_pkg::reg_addr_t exp_reg_q [$];
   mips_pkg::word_t     exp_val_q [$];
   mips_pkg::word_t     exp_pc_q [$];
   mips_pkg::word_t     exp_st_addr_q [$];
   mips_pkg::word_t     exp_st_data_q [$];
   mips_pkg::word_t     exp_st_pc_q [$];

   cpu #(.RESET_PC(RESET_PC)) u_cpu (
      .clk(clk), .rst(rst),
      .i_inst_addr(i_inst_addr), .i_inst_rdata(i_inst_rdata),
      .m_data_addr(m_data_addr), .m_data_wdata(m_data_wdata),
      .m_data_byteen(m_data_byteen), .m_inst_addr(m_inst_addr),
      .m_data_rdata(m_data_rdata),
      .w_grf_we(w_grf_we), .w_grf_addr(w_grf_addr),
      .w_grf_wdata(w_grf_wdata), .w_inst_addr(w_inst_addr)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   function automatic logic [15:0] rand_imm();
      logic [31:0] r;
      r = next_rand();
      return r[31:16];
   endfunction

   function automatic mips_pkg::reg_addr_t rand_reg();
      logic [31:0] r;
      r = next_rand();
      return mips_pkg::reg_addr_t'(1 + r[31:16] % 15);
   endfunction

   // word-aligned offset inside the data memory
   function automatic logic [15:0] rand_off();
      logic [31:0] r;
      r = next_rand();
      return {8'h00, r[21:16], 2'b00};
   endfunction

   function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t addr);
      return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
   endfunction

   function automatic mips_pkg::word_t enc_r(input mips_pkg::reg_addr_t rs, rt, rd,
                                             input logic [5:0] fn);
      return {mips_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic mips_pkg::word_t enc_i(input logic [5:0] op,
                                             input mips_pkg::reg_addr_t rs, rt,
                                             input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic mips_pkg::word_t enc_j(input mips_pkg::word_t target);
      return {mips_pkg::OP_J, target[27:2]};
   endfunction

   function automatic mips_pkg::word_t addr_of(input int n);
      return RESET_PC + 32'(n) * 32'd4;
   endfunction

   function automatic mips_pkg::word_t rom_word(input mips_pkg::word_t addr);
      mips_pkg::word_t idx;
      if ($isunknown(addr) || addr < RESET_PC) begin
         return '0;
      end
      idx = (addr - RESET_PC) >> 2;
      if (idx >= 32'(prog_len)) begin
         return '0;
      end
      return prog[idx];
   endfunction

   task automatic emit(input mips_pkg::word_t instr);
      prog[prog_len] = instr;
      prog_len++;
   endtask

   task automatic build_program();
      mips_pkg::reg_addr_t d;
      mips_pkg::reg_addr_t p1;
      mips_pkg::reg_addr_t p2;
      logic [15:0] off;
      prog_len = 0;
      // lui then a dependent ori
      for (int r = 1; r <= 8; r++) begin
         emit(enc_i(mips_pkg::OP_LUI, 5'd0, 5'(r), rand_imm()));
         emit(enc_i(mips_pkg::OP_ORI, 5'(r), 5'(r), rand_imm()));
      end
      // each one reads the last two results
      p1 = 5'd1;
      p2 = 5'd2;
      for (int k = 0; k < 8; k++) begin
         d = rand_reg();
         emit(enc_r(p1, p2, d, k[0] ? mips_pkg::FN_SUBU : mips_pkg::FN_ADDU));
         p2 = p1;
         p1 = d;
      end
      for (int k = 0; k < 4; k++) begin
         off = rand_off();
         d = rand_reg();
         emit(enc_r(p1, d, d, mips_pkg::FN_ADDU));
         emit(enc_i(mips_pkg::OP_SW, 5'd0, d, off));
         p1 = rand_reg();
         emit(enc_i(mips_pkg::OP_LW, 5'd0, p1, off));
      end
      // load-use
      for (int k = 0; k < 3; k++) begin
         d = rand_reg();
         emit(enc_i(mips_pkg::OP_LW, 5'd0, d, rand_off()));
         emit(enc_r(d, p1, rand_reg(), mips_pkg::FN_SUBU));
         p1 = d;
      end
      // taken, alu result still in execute
      emit(enc_r(5'd1, 5'd0, 5'd16, mips_pkg::FN_ADDU));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd16, 5'd1, 16'd2));
      emit(enc_r(5'd2, 5'd3, 5'd17, mips_pkg::FN_ADDU));
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd18, 16'h1111));
      // not taken, lui comes from execute
      emit(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd22, 16'h8001));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd22, 5'd0, 16'd2));
      emit(enc_r(5'd22, 5'd1, 5'd24, mips_pkg::FN_SUBU));
      emit(enc_r(5'd24, 5'd22, 5'd25, mips_pkg::FN_ADDU));
      // load in execute, taken only on the loaded value
      off = rand_off();
      emit(enc_i(mips_pkg::OP_LW, 5'd0, 5'd23, off));
      emit(enc_i(mips_pkg::OP_LW, 5'd0, 5'd19, off));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd19, 5'd23, 16'd2));
      emit(enc_i(mips_pkg::OP_ORI, 5'd19, 5'd20, 16'h0001));
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd18, 16'h2222));
      // load in memory
      emit(enc_i(mips_pkg::OP_LW, 5'd0, 5'd21, off));
      emit(enc_r(5'd1, 5'd2, 5'd26, mips_pkg::FN_ADDU));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd21, 5'd23, 16'd2));
      emit(enc_r(5'd21, 5'd26, 5'd27, mips_pkg::FN_ADDU));
      emit(enc_i(mips_pkg::OP_ORI, 5'd21, 5'd28, 16'h0003));
      emit(enc_r(5'd27, 5'd28, 5'd29, mips_pkg::FN_ADDU));
      // jump over one instruction
      emit(enc_j(addr_of(prog_len + 3)));
      emit(enc_i(mips_pkg::OP_ORI, 5'd1, 5'd27, 16'h0055));
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd28, 16'h0077));
      emit(enc_r(5'd27, 5'd1, 5'd29, mips_pkg::FN_ADDU));
      loop_addr = addr_of(prog_len);
      emit(enc_j(loop_addr));
      emit('0);
   endtask

   task automatic ref_write(input mips_pkg::reg_addr_t rd, input mips_pkg::word_t val,
                            input mips_pkg::word_t pc);
      if (rd != 5'd0) begin
         ref_regs[rd] = val;
         exp_reg_q.push_back(rd);
         exp_val_q.push_back(val);
         exp_pc_q.push_back(pc);
      end
   endtask

   // in-order model with one delay slot
   task automatic run_reference();
      mips_pkg::word_t pc;
      mips_pkg::word_t npc;
      mips_pkg::word_t nnpc;
      mips_pkg::word_t ins;
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      mips_pkg::word_t addr;
      mips_pkg::word_t slot;
      mips_pkg::word_t sext;
      int steps;
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
         ref_mem[i] = fill_word(32'(i) * 32'd4);
      end
      pc = RESET_PC;
      npc = RESET_PC + 32'd4;
      steps = 0;
      while (pc != loop_addr && steps < 4000) begin
         ins = rom_word(pc);
         a = ref_regs[ins[25:21]];
         b = ref_regs[ins[20:16]];
         sext = {{16{ins[15]}}, ins[15:0]};
         slot = pc + 32'd4;
         nnpc = npc + 32'd4;
         case (ins[31:26])
            mips_pkg::OP_SPECIAL: begin
               if (ins[5:0] == mips_pkg::FN_ADDU) begin
                  ref_write(ins[15:11], a + b, pc);
               end else if (ins[5:0] == mips_pkg::FN_SUBU) begin
                  ref_write(ins[15:11], a - b, pc);
               end
            end
            mips_pkg::OP_ORI: ref_write(ins[20:16], a | {16'h0000, ins[15:0]}, pc);
            mips_pkg::OP_LUI: ref_write(ins[20:16], {ins[15:0], 16'h0000}, pc);
            mips_pkg::OP_LW: begin
               addr = a + sext;
               ref_write(ins[20:16], ref_mem[addr[7:2]], pc);
            end
            mips_pkg::OP_SW: begin
               addr = a + sext;
               ref_mem[addr[7:2]] = b;
               exp_st_addr_q.push_back(addr);
               exp_st_data_q.push_back(b);
               exp_st_pc_q.push_back(pc);
            end
            mips_pkg::OP_BEQ: begin
               if (a == b) begin
                  nnpc = slot + {sext[29:0], 2'b00};
               end
            end
            mips_pkg::OP_J: nnpc = {slot[31:28], ins[25:0], 2'b00};
            default: nnpc = npc + 32'd4;
         endcase
         pc = npc;
         npc = nnpc;
         steps++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // combinational memories, answered 1 ns after the edge
   always @(posedge clk) begin
      #1;
      i_inst_rdata = rom_word(i_inst_addr);
      m_data_rdata = $isunknown(m_data_addr) ? '0 : dmem[m_data_addr[7:2]];
   end

   always @(negedge clk) begin
      if (!rst && built) begin
         if (w_grf_we === 1'b1) begin
            write_count++;
            if (exp_reg_q.size() == 0) begin
               err_count++;
               $display("unexpected write to r%0d at %0t after all expected writes",
                        w_grf_addr, $time);
            end else begin
               assert (w_grf_addr == exp_reg_q[0] && w_grf_wdata == exp_val_q[0] &&
                       w_inst_addr == exp_pc_q[0])
               else begin
                  err_count++;
                  $display("Mismatch at %0t: r%0d=%h from %h, expected r%0d=%h from %h",
                           $time, w_grf_addr, w_grf_wdata, w_inst_addr,
                           exp_reg_q[0], exp_val_q[0], exp_pc_q[0]);
               end
               void'(exp_reg_q.pop_front());
               void'(exp_val_q.pop_front());
               void'(exp_pc_q.pop_front());
            end
         end
         if (m_data_byteen === 4'hf) begin
            store_count++;
            if (exp_st_addr_q.size() == 0) begin
               err_count++;
               $display("unexpected store to %h at %0t", m_data_addr, $time);
            end else begin
               assert (m_data_addr == exp_st_addr_q[0] && m_data_wdata == exp_st_data_q[0] &&
                       m_inst_addr == exp_st_pc_q[0])
               else begin
                  err_count++;
                  $display("Mismatch at %0t: store %h to %h from %h, expected %h to %h from %h",
                           $time, m_data_wdata, m_data_addr, m_inst_addr,
                           exp_st_data_q[0], exp_st_addr_q[0], exp_st_pc_q[0]);
               end
               void'(exp_st_addr_q.pop_front());
               void'(exp_st_data_q.pop_front());
               void'(exp_st_pc_q.pop_front());
            end
            dmem[m_data_addr[7:2]] = m_data_wdata;
         end
      end
   end

   // watchdog
   initial begin
      wait (built === 1'b1);
      repeat (prog_len * 20 + 100) @(posedge clk);
      $display("timeout: the final loop was never reached in writeback");
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      rst = 1'b1;
      i_inst_rdata = '0;
      m_data_rdata = '0;
      built = 1'b0;
      rng_state = 32'd24;
      err_count = 0;
      write_count = 0;
      store_count = 0;
      for (int i = 0; i < 64; i++) begin
         dmem[i] = fill_word(32'(i) * 32'd4);
      end
      build_program();
      run_reference();
      exp_writes = exp_reg_q.size();
      built = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      while (w_inst_addr !== loop_addr) @(negedge clk);
      assert (write_count == exp_writes)
      else begin
         err_count++;
         $display("Mismatch at %0t: %0d register writes seen, %0d expected", $time,
                  write_count, exp_writes);
      end
      assert (exp_reg_q.size() == 0 && exp_st_addr_q.size() == 0)
      else begin
         err_count++;
         $display("%0d register writes and %0d stores never appeared",
                  exp_reg_q.size(), exp_st_addr_q.size());
      end
      $display("writes %0d of %0d, stores %0d, errors %0d", write_count, exp_writes,
               store_count, err_count);
      if (err_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
